//--- common/cpu8_defs.svh
`ifndef CPU8_DEFS_SVH
`define CPU8_DEFS_SVH

// Datapath and bus widths
`define CPU8_DATA_W   8
`define CPU8_ADDR_W   8

// Four architectural registers with the JAL link in the last one
`define CPU8_NUM_REGS 4

// First fetch address out of reset
`define CPU8_RESET_PC 8'h00

`endif

//--- common/cpu8_pkg.sv
`include "cpu8_defs.svh"

package cpu8_pkg;

    typedef logic [`CPU8_DATA_W-1:0] word_t;                 // Data or address word
    typedef logic [$clog2(`CPU8_NUM_REGS)-1:0] reg_idx_t;    // Register index

    // Instruction bits 7:4
    typedef enum logic [3:0]
    {
        OP_MOV,
        OP_ADD,
        OP_AND,
        OP_NOT,
        OP_NOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_JMP,
        OP_JAL,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_ADDI,
        OP_LI
    } opcode_t;

    typedef enum logic [1:0]
    {
        ST_FETCH,   // Instruction read at pc
        ST_EXEC,    // Register ops and pc update
        ST_MEM,     // Load or store bus cycle
        ST_WRITE    // Load data into ra
    } ctrl_state_t;

endpackage

//--- common/cpu8_wb_if.sv
`timescale 1ns/1ps
`include "cpu8_defs.svh"

interface cpu8_wb_if;

    logic [`CPU8_ADDR_W-1:0] adr;
    logic [`CPU8_DATA_W-1:0] dat_w;     // Master to slave
    logic [`CPU8_DATA_W-1:0] dat_r;     // Slave to master
    logic                    we;
    logic                    cyc;
    logic                    stb;
    logic                    ack;       // Transfer completes on this edge

    modport master
    (
        output adr,
        output dat_w,
        output we,
        output cyc,
        output stb,
        input  dat_r,
        input  ack
    );

    modport slave
    (
        input  adr,
        input  dat_w,
        input  we,
        input  cyc,
        input  stb,
        output dat_r,
        output ack
    );

endinterface

//--- flist.f
+incdir+common
common/cpu8_pkg.sv
common/cpu8_wb_if.sv
hw/cpu8_alu.sv
hw/cpu8_regfile.sv
hw/cpu8_pc_unit.sv
hw/cpu8_control.sv
hw/cpu8_top.sv
verif/cpu8_wb_mem.sv
verif/cpu8_tb.sv

//--- hw/cpu8_alu.sv
`timescale 1ns/1ps
`include "cpu8_defs.svh"

// a is the ra operand, b the rb operand
module cpu8_alu
(
    input  cpu8_pkg::opcode_t opcode,
    input  cpu8_pkg::word_t   a,
    input  cpu8_pkg::word_t   b,
    input  logic [1:0]        imm2,
    output cpu8_pkg::word_t   result,
    output logic              skip,
    output logic              overflow
);

    cpu8_pkg::word_t imm_sext;
    cpu8_pkg::word_t sum;
    cpu8_pkg::word_t sum_imm;

    assign imm_sext = {{(`CPU8_DATA_W-2){imm2[1]}}, imm2};   // -2..1
    assign sum      = b + a;
    assign sum_imm  = a + imm_sext;

    always_comb
    begin
        result = a;         // Jumps and memory ops pass ra through
        case (opcode)
            cpu8_pkg::OP_MOV:
            begin
                result = b;
            end
            cpu8_pkg::OP_ADD:
            begin
                result = sum;
            end
            cpu8_pkg::OP_AND:
            begin
                result = b & a;
            end
            cpu8_pkg::OP_NOT:
            begin
                result = ~b;
            end
            cpu8_pkg::OP_NOR:
            begin
                result = ~(b | a);
            end
            cpu8_pkg::OP_SLT:
            begin
                result = ($signed(a) < $signed(b)) ? cpu8_pkg::word_t'(1) : '0;
            end
            cpu8_pkg::OP_SLL:
            begin
                result = a << imm2;     // Shift amount read unsigned
            end
            cpu8_pkg::OP_SRL:
            begin
                result = a >> imm2;
            end
            cpu8_pkg::OP_ADDI:
            begin
                result = sum_imm;
            end
            cpu8_pkg::OP_LI:
            begin
                result = imm_sext;
            end
            default:
            begin
                result = a;
            end
        endcase
    end

    // Branches become a skip of the following instruction
    always_comb
    begin
        case (opcode)
            cpu8_pkg::OP_BEQ: skip = (a == b);
            cpu8_pkg::OP_BNE: skip = (a != b);
            default:          skip = 1'b0;
        endcase
    end

    // Same operand signs, different result sign
    assign overflow = (opcode == cpu8_pkg::OP_ADD)
                    && (a[`CPU8_DATA_W-1] == b[`CPU8_DATA_W-1])
                    && (sum[`CPU8_DATA_W-1] != a[`CPU8_DATA_W-1]);

endmodule

//--- hw/cpu8_control.sv
`timescale 1ns/1ps
`include "cpu8_defs.svh"

module cpu8_control
(
    input  logic                clk,
    input  logic                reset,
    cpu8_wb_if.master           bus,
    output cpu8_pkg::reg_idx_t  rd_a,
    output cpu8_pkg::reg_idx_t  rd_b,
    input  cpu8_pkg::word_t     data_a,
    input  cpu8_pkg::word_t     data_b,
    output cpu8_pkg::opcode_t   alu_op,
    output logic [1:0]          alu_imm2,
    input  cpu8_pkg::word_t     alu_result,
    input  logic                alu_skip,
    input  logic                alu_overflow,
    output logic                reg_we,
    output cpu8_pkg::reg_idx_t  reg_wr_idx,
    output cpu8_pkg::word_t     reg_wr_data,
    input  cpu8_pkg::word_t     pc,
    input  cpu8_pkg::word_t     pc_next_seq,
    output logic                pc_advance,
    output logic                pc_skip,
    output logic                pc_jump,
    output cpu8_pkg::word_t     pc_target,
    output logic                overflow
);

    cpu8_pkg::ctrl_state_t   state;
    cpu8_pkg::word_t         ir;            // Instruction register
    cpu8_pkg::word_t         load_data;
    logic [`CPU8_ADDR_W-1:0] adr_q;
    cpu8_pkg::word_t         dat_w_q;
    logic                    we_q;
    logic                    cyc_q;
    logic                    bus_done;
    logic                    is_mem;

    assign alu_op   = cpu8_pkg::opcode_t'(ir[7:4]);
    assign rd_a     = ir[3:2];              // ra, destination
    assign rd_b     = ir[1:0];              // rb
    assign alu_imm2 = ir[1:0];

    assign bus_done = cyc_q && bus.ack;
    assign is_mem   = (alu_op == cpu8_pkg::OP_LW) || (alu_op == cpu8_pkg::OP_SW);

    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_w_q;
    assign bus.we    = we_q;
    assign bus.cyc   = cyc_q;
    assign bus.stb   = cyc_q;               // Single transfer per cycle

    // PC moves once per instruction, in the execute cycle
    assign pc_advance = (state == cpu8_pkg::ST_EXEC);
    assign pc_skip    = alu_skip;
    assign pc_jump    = (alu_op == cpu8_pkg::OP_JMP) || (alu_op == cpu8_pkg::OP_JAL);
    assign pc_target  = data_a;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= cpu8_pkg::ST_FETCH;
            cyc_q    <= 1'b0;
            we_q     <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            case (state)
                cpu8_pkg::ST_FETCH:
                begin
                    if (!cyc_q)
                    begin
                        cyc_q <= 1'b1;      // Read at pc
                        we_q  <= 1'b0;
                    end
                    else if (bus.ack)
                    begin
                        cyc_q <= 1'b0;
                        state <= cpu8_pkg::ST_EXEC;
                    end
                end
                cpu8_pkg::ST_EXEC:
                begin
                    if (alu_op == cpu8_pkg::OP_ADD)
                    begin
                        overflow <= alu_overflow;
                    end
                    state <= is_mem ? cpu8_pkg::ST_MEM : cpu8_pkg::ST_FETCH;
                end
                cpu8_pkg::ST_MEM:
                begin
                    if (!cyc_q)
                    begin
                        cyc_q <= 1'b1;
                        we_q  <= (alu_op == cpu8_pkg::OP_SW);
                    end
                    else if (bus.ack)
                    begin
                        cyc_q <= 1'b0;
                        we_q  <= 1'b0;
                        state <= (alu_op == cpu8_pkg::OP_LW) ? cpu8_pkg::ST_WRITE
                                                             : cpu8_pkg::ST_FETCH;
                    end
                end
                default:
                begin
                    state <= cpu8_pkg::ST_FETCH;    // Load write-back done
                end
            endcase
        end
    end

    // Address, write data and captured read data
    always_ff @(posedge clk)
    begin
        if (!cyc_q && state == cpu8_pkg::ST_FETCH)
        begin
            adr_q <= pc;
        end
        else if (!cyc_q && state == cpu8_pkg::ST_MEM)
        begin
            adr_q   <= data_b;                  // Address from rb
            dat_w_q <= data_a;                  // Store data from ra
        end
        if (bus_done && state == cpu8_pkg::ST_FETCH)
        begin
            ir <= bus.dat_r;
        end
        if (bus_done && state == cpu8_pkg::ST_MEM)
        begin
            load_data <= bus.dat_r;
        end
    end

    always_comb
    begin
        reg_we      = 1'b0;
        reg_wr_idx  = rd_a;
        reg_wr_data = alu_result;
        if (state == cpu8_pkg::ST_WRITE)
        begin
            reg_we      = 1'b1;
            reg_wr_data = load_data;
        end
        else if (state == cpu8_pkg::ST_EXEC)
        begin
            case (alu_op)
                cpu8_pkg::OP_JAL:
                begin
                    reg_we      = 1'b1;
                    reg_wr_idx  = cpu8_pkg::reg_idx_t'(`CPU8_NUM_REGS - 1);  // Link register
                    reg_wr_data = pc_next_seq;
                end
                cpu8_pkg::OP_JMP, cpu8_pkg::OP_LW, cpu8_pkg::OP_SW,
                cpu8_pkg::OP_BEQ, cpu8_pkg::OP_BNE:
                begin
                    reg_we = 1'b0;      // No register result
                end
                default:
                begin
                    reg_we = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hw/cpu8_pc_unit.sv
`timescale 1ns/1ps
`include "cpu8_defs.svh"

module cpu8_pc_unit
(
    input  logic             clk,
    input  logic             reset,
    input  logic             advance,
    input  logic             skip,
    input  logic             jump,
    input  cpu8_pkg::word_t  target,
    output cpu8_pkg::word_t  pc,
    output cpu8_pkg::word_t  pc_next_seq
);

    cpu8_pkg::word_t pc_next;

    assign pc_next_seq = pc + 8'd1;     // Also the JAL link value

    always_comb
    begin
        if (jump)
        begin
            pc_next = target;
        end
        else if (skip)
        begin
            pc_next = pc + 8'd2;        // Step over the next instruction
        end
        else
        begin
            pc_next = pc_next_seq;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= cpu8_pkg::word_t'(`CPU8_RESET_PC);
        end
        else if (advance)
        begin
            pc <= pc_next;
        end
    end

endmodule

//--- hw/cpu8_regfile.sv
`timescale 1ns/1ps
`include "cpu8_defs.svh"

module cpu8_regfile
(
    input  logic                clk,
    input  logic                reset,
    input  cpu8_pkg::reg_idx_t  rd_a,
    input  cpu8_pkg::reg_idx_t  rd_b,
    output cpu8_pkg::word_t     data_a,
    output cpu8_pkg::word_t     data_b,
    input  logic                we,
    input  cpu8_pkg::reg_idx_t  wr_idx,
    input  cpu8_pkg::word_t     wr_data
);

    cpu8_pkg::word_t regs [`CPU8_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU8_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[wr_idx] <= wr_data;    // ALU result, link or load data
        end
    end

    // Reads see the old value during a write cycle
    assign data_a = regs[rd_a];
    assign data_b = regs[rd_b];

endmodule

//--- hw/cpu8_top.sv
`timescale 1ns/1ps
`include "cpu8_defs.svh"

module cpu8_top
(
    input  logic                    clk,
    input  logic                    reset,
    output logic [`CPU8_ADDR_W-1:0] wb_adr,
    output cpu8_pkg::word_t         wb_wdata,
    input  cpu8_pkg::word_t         wb_rdata,
    output logic                    wb_we,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    input  logic                    wb_ack,
    output logic                    overflow
);

    cpu8_pkg::reg_idx_t rd_a;
    cpu8_pkg::reg_idx_t rd_b;
    cpu8_pkg::word_t    data_a;
    cpu8_pkg::word_t    data_b;
    cpu8_pkg::opcode_t  alu_op;
    logic [1:0]         alu_imm2;
    cpu8_pkg::word_t    alu_result;
    logic               alu_skip;
    logic               alu_overflow;
    logic               reg_we;
    cpu8_pkg::reg_idx_t reg_wr_idx;
    cpu8_pkg::word_t    reg_wr_data;
    cpu8_pkg::word_t    pc;
    cpu8_pkg::word_t    pc_next_seq;
    logic               pc_advance;
    logic               pc_skip;
    logic               pc_jump;
    cpu8_pkg::word_t    pc_target;

    cpu8_wb_if bus ();

    // Slave side of the bus goes out as plain ports
    assign wb_adr    = bus.adr;
    assign wb_wdata  = bus.dat_w;
    assign wb_we     = bus.we;
    assign wb_cyc    = bus.cyc;
    assign wb_stb    = bus.stb;
    assign bus.dat_r = wb_rdata;
    assign bus.ack   = wb_ack;

    cpu8_control u_control
    (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus.master),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .data_a       (data_a),
        .data_b       (data_b),
        .alu_op       (alu_op),
        .alu_imm2     (alu_imm2),
        .alu_result   (alu_result),
        .alu_skip     (alu_skip),
        .alu_overflow (alu_overflow),
        .reg_we       (reg_we),
        .reg_wr_idx   (reg_wr_idx),
        .reg_wr_data  (reg_wr_data),
        .pc           (pc),
        .pc_next_seq  (pc_next_seq),
        .pc_advance   (pc_advance),
        .pc_skip      (pc_skip),
        .pc_jump      (pc_jump),
        .pc_target    (pc_target),
        .overflow     (overflow)
    );

    cpu8_alu u_alu
    (
        .opcode   (alu_op),
        .a        (data_a),
        .b        (data_b),
        .imm2     (alu_imm2),
        .result   (alu_result),
        .skip     (alu_skip),
        .overflow (alu_overflow)
    );

    cpu8_regfile u_regfile
    (
        .clk     (clk),
        .reset   (reset),
        .rd_a    (rd_a),
        .rd_b    (rd_b),
        .data_a  (data_a),
        .data_b  (data_b),
        .we      (reg_we),
        .wr_idx  (reg_wr_idx),
        .wr_data (reg_wr_data)
    );

    cpu8_pc_unit u_pc_unit
    (
        .clk         (clk),
        .reset       (reset),
        .advance     (pc_advance),
        .skip        (pc_skip),
        .jump        (pc_jump),
        .target      (pc_target),
        .pc          (pc),
        .pc_next_seq (pc_next_seq)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line appears
verilator --binary --timing --top-module cpu8_tb -f flist.f -o cpu8_sim \
    && out=$(./obj_dir/cpu8_sim) \
    && echo "$out" \
    && echo "$out" | grep -qx "Test OK" \
    || { echo "simulation did not pass"; exit 1; }

//--- verif/cpu8_tb.sv
`timescale 1ns/1ps

module cpu8_tb;

    localparam int MAX_STEPS = 64;
    localparam int NUM_TESTS = 6;
    localparam int LIMIT     = MAX_STEPS * NUM_TESTS * 12;

    logic       clk;
    logic       reset;
    logic [7:0] wb_adr;
    logic [7:0] wb_wdata;
    logic [7:0] wb_rdata;
    logic       wb_we;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_ack;
    logic       overflow;
    logic [1:0] ack_delay;
    logic       clear;
    logic       load;
    logic [7:0] load_adr;
    logic [7:0] load_dat;

    logic [31:0] delay_rng;
    logic [31:0] prog_rng;
    logic [7:0]  img [256];         // Program image being built
    logic [7:0]  wr_pos;
    int          hi;
    logic [7:0]  end_pc;            // Address of the final store
    logic        running;
    int          errors;
    int          stores;
    int          cycles;
    int          passed;
    int          failed;

    // Reference machine state
    logic [7:0] ref_regs [4];
    logic [7:0] ref_mem [256];
    logic [7:0] ref_pc;
    logic       ref_ov;

    logic       found;
    int         steps;
    logic [7:0] s_pc;
    logic [7:0] s_adr;
    logic [7:0] s_dat;

    cpu8_top dut0
    (
        .clk      (clk),
        .reset    (reset),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack),
        .overflow (overflow)
    );

    cpu8_wb_mem mem0
    (
        .clk       (clk),
        .reset     (reset),
        .adr       (wb_adr),
        .dat_w     (wb_wdata),
        .dat_r     (wb_rdata),
        .we        (wb_we),
        .cyc       (wb_cyc),
        .stb       (wb_stb),
        .ack       (wb_ack),
        .ack_delay (ack_delay),
        .clear     (clear),
        .load      (load),
        .load_adr  (load_adr),
        .load_dat  (load_dat)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 37) ^ 8'h5a;
    endfunction

    function automatic logic [7:0] enc(input cpu8_pkg::opcode_t op, input logic [1:0] ra,
                                       input logic [1:0] rb);
        return {op, ra, rb};
    endfunction

    // One instruction on the model, the return value flags a store
    function automatic logic cpu8_ref_step(output logic [7:0] st_pc, output logic [7:0] st_adr,
                                           output logic [7:0] st_dat);
        logic [7:0] ins;
        logic [1:0] ra;
        logic [1:0] rb;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] imm;
        logic [7:0] sum;
        int         ssum;
        logic [7:0] next;
        logic       is_store;
        ins      = ref_mem[ref_pc];
        ra       = ins[3:2];
        rb       = ins[1:0];
        a        = ref_regs[ra];
        b        = ref_regs[rb];
        imm      = {{6{rb[1]}}, rb};
        next     = ref_pc + 8'd1;
        is_store = 1'b0;
        st_pc    = ref_pc;
        st_adr   = b;
        st_dat   = a;
        case (cpu8_pkg::opcode_t'(ins[7:4]))
            cpu8_pkg::OP_MOV:  ref_regs[ra] = b;
            cpu8_pkg::OP_ADD:
            begin
                sum          = a + b;
                ssum         = int'($signed(a)) + int'($signed(b));
                ref_ov       = (ssum > 127) || (ssum < -128);   // Outside the 8-bit signed range
                ref_regs[ra] = sum;
            end
            cpu8_pkg::OP_AND:  ref_regs[ra] = a & b;
            cpu8_pkg::OP_NOT:  ref_regs[ra] = ~b;
            cpu8_pkg::OP_NOR:  ref_regs[ra] = ~(a | b);
            cpu8_pkg::OP_SLT:  ref_regs[ra] = {7'd0, $signed(a) < $signed(b)};
            cpu8_pkg::OP_SLL:  ref_regs[ra] = a << rb;
            cpu8_pkg::OP_SRL:  ref_regs[ra] = a >> rb;
            cpu8_pkg::OP_JMP:  next = a;
            cpu8_pkg::OP_JAL:
            begin
                next        = a;
                ref_regs[3] = ref_pc + 8'd1;
            end
            cpu8_pkg::OP_LW:   ref_regs[ra] = ref_mem[b];
            cpu8_pkg::OP_SW:
            begin
                ref_mem[b] = a;
                is_store   = 1'b1;
            end
            cpu8_pkg::OP_BEQ:  next = (a == b) ? ref_pc + 8'd2 : next;
            cpu8_pkg::OP_BNE:  next = (a != b) ? ref_pc + 8'd2 : next;
            cpu8_pkg::OP_ADDI: ref_regs[ra] = a + imm;
            default:           ref_regs[ra] = imm;
        endcase
        ref_pc = next;
        return is_store;
    endfunction

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic new_prog();
        for (int i = 0; i < 256; i++)
        begin
            img[i] = fill_byte(i);
        end
        wr_pos = 8'd0;
        hi     = 0;
    endtask

    task automatic put(input logic [7:0] ins);
        img[wr_pos] = ins;
        if (int'(wr_pos) > hi)
        begin
            hi = int'(wr_pos);
        end
        wr_pos = wr_pos + 8'd1;
    endtask

    // Register dump ending in a self jump stored at 8'hff
    task automatic end_seq();
        put(enc(cpu8_pkg::OP_SW, 2'd0, 2'd0));
        put(enc(cpu8_pkg::OP_LI, 2'd0, 2'b10));
        put(enc(cpu8_pkg::OP_SW, 2'd1, 2'd0));
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd0));
        put(enc(cpu8_pkg::OP_MOV, 2'd1, 2'd0));
        put(enc(cpu8_pkg::OP_SLL, 2'd1, 2'd3));
        put(enc(cpu8_pkg::OP_SLL, 2'd1, 2'd3));     // Encoding of JMP r0
        put(enc(cpu8_pkg::OP_LI, 2'd0, 2'b11));
        end_pc = wr_pos;
        put(enc(cpu8_pkg::OP_SW, 2'd1, 2'd0));
        put(enc(cpu8_pkg::OP_JMP, 2'd0, 2'd0));
    endtask

    task automatic random_body(input int count);
        logic [3:0] op;
        for (int i = 0; i < count; i++)
        begin
            prog_rng = xorshift(prog_rng);
            op       = prog_rng[7:4];
            if (op == 4'd8 || op == 4'd9 || op == 4'd11)
            begin
                op = 4'd1;              // No jumps or stores in the body
            end
            put({op, prog_rng[11:8]});
        end
    endtask

    task automatic run_test(input int num, input string name);
        int err0;
        err0 = errors;
        @(posedge clk);
        load  <= 1'b1;
        clear <= 1'b1;
        for (int i = 0; i <= hi; i++)
        begin
            @(posedge clk);
            clear    <= 1'b0;
            load_adr <= 8'(i);
            load_dat <= img[i];
        end
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 256; i++)
        begin
            ref_mem[i] = img[i];
        end
        for (int i = 0; i < 4; i++)
        begin
            ref_regs[i] = 8'd0;
        end
        ref_pc  = 8'd0;
        ref_ov  = 1'b0;
        stores  = 0;
        reset   <= 1'b0;
        load    <= 1'b0;
        running <= 1'b1;
        @(posedge clk);
        while (running)
        begin
            @(posedge clk);
        end
        if (errors == err0)
        begin
            $display("test %0d %s: passed, %0d stores checked", num, name, stores);
            passed++;
        end
        else
        begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err0);
            failed++;
        end
    endtask

    always @(posedge clk)
    begin
        delay_rng = xorshift(delay_rng);
        ack_delay <= delay_rng[1:0];
    end

    // Each acknowledged write is matched against the model's next store
    always @(posedge clk)
    begin
        if (running && wb_cyc && wb_stb && wb_we && wb_ack)
        begin
            found = 1'b0;
            steps = 0;
            while (!found && steps < MAX_STEPS)
            begin
                found = cpu8_ref_step(s_pc, s_adr, s_dat);
                steps++;
            end
            if (!found)
            begin
                $display("DUT stored to %h but the model ran %0d steps without a store",
                         wb_adr, MAX_STEPS);
                errors++;
                running <= 1'b0;
            end
            else
            begin
                check("wb_adr", wb_adr, s_adr);
                check("wb_wdata", wb_wdata, s_dat);
                check("overflow", {7'd0, overflow}, {7'd0, ref_ov});
                stores++;
                if (s_pc == end_pc)
                begin
                    running <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        if (running)
        begin
            cycles++;
            if (cycles >= LIMIT)
            begin
                $display("Timeout: the DUT did not reach the end of the test in %0d cycles",
                         LIMIT);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        ack_delay = 2'd0;
        clear     = 1'b0;
        load      = 1'b0;
        load_adr  = 8'd0;
        load_dat  = 8'd0;
        running   = 1'b0;
        delay_rng = 32'h5d98_902d;
        prog_rng  = 32'h5d98_902d;
        errors    = 0;
        cycles    = 0;
        passed    = 0;
        failed    = 0;

        new_prog();
        put(enc(cpu8_pkg::OP_LI, 2'd0, 2'b01));
        put(enc(cpu8_pkg::OP_LI, 2'd1, 2'b10));
        put(enc(cpu8_pkg::OP_LI, 2'd2, 2'b11));
        put(enc(cpu8_pkg::OP_ADDI, 2'd2, 2'b10));
        put(enc(cpu8_pkg::OP_MOV, 2'd3, 2'd1));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd2));
        put(enc(cpu8_pkg::OP_AND, 2'd3, 2'd2));
        put(enc(cpu8_pkg::OP_NOT, 2'd1, 2'd0));
        put(enc(cpu8_pkg::OP_NOR, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_SLL, 2'd3, 2'd3));
        put(enc(cpu8_pkg::OP_SRL, 2'd1, 2'd1));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd1));
        end_seq();
        run_test(1, "logic and shifts");

        new_prog();
        put(enc(cpu8_pkg::OP_LI, 2'd0, 2'b01));
        put(enc(cpu8_pkg::OP_LI, 2'd1, 2'b10));
        put(enc(cpu8_pkg::OP_ADD, 2'd0, 2'd1));
        put(enc(cpu8_pkg::OP_LI, 2'd2, 2'b01));
        put(enc(cpu8_pkg::OP_SLL, 2'd2, 2'd3));
        put(enc(cpu8_pkg::OP_SLL, 2'd2, 2'd3));
        put(enc(cpu8_pkg::OP_ADD, 2'd2, 2'd2));     // 0x40 + 0x40 overflows
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd1));
        put(enc(cpu8_pkg::OP_LI, 2'd3, 2'b01));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd1));
        put(enc(cpu8_pkg::OP_ADD, 2'd3, 2'd0));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd1));
        put(enc(cpu8_pkg::OP_ADD, 2'd2, 2'd2));     // 0x80 + 0x80 overflows
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd1));
        put(enc(cpu8_pkg::OP_ADDI, 2'd2, 2'b01));
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd1));
        end_seq();
        run_test(2, "add and overflow");

        new_prog();
        put(enc(cpu8_pkg::OP_LI, 2'd0, 2'b10));
        put(enc(cpu8_pkg::OP_LI, 2'd1, 2'b01));
        put(enc(cpu8_pkg::OP_MOV, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_SLT, 2'd2, 2'd1));
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_MOV, 2'd3, 2'd1));
        put(enc(cpu8_pkg::OP_SLT, 2'd3, 2'd0));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd0));
        put(enc(cpu8_pkg::OP_BEQ, 2'd2, 2'd1));     // Taken
        put(enc(cpu8_pkg::OP_SW, 2'd0, 2'd0));
        put(enc(cpu8_pkg::OP_BNE, 2'd2, 2'd1));     // Not taken
        put(enc(cpu8_pkg::OP_ADDI, 2'd2, 2'b01));
        put(enc(cpu8_pkg::OP_BNE, 2'd3, 2'd1));     // Taken
        put(enc(cpu8_pkg::OP_LI, 2'd3, 2'b11));
        put(enc(cpu8_pkg::OP_BEQ, 2'd3, 2'd1));     // Not taken
        put(enc(cpu8_pkg::OP_ADDI, 2'd3, 2'b10));
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd0));
        end_seq();
        run_test(3, "compare and branch");

        new_prog();
        put(enc(cpu8_pkg::OP_LI, 2'd0, 2'b10));
        put(enc(cpu8_pkg::OP_LI, 2'd1, 2'b01));
        put(enc(cpu8_pkg::OP_SLL, 2'd1, 2'd3));
        put(enc(cpu8_pkg::OP_SLL, 2'd1, 2'd3));
        put(enc(cpu8_pkg::OP_SW, 2'd0, 2'd1));
        put(enc(cpu8_pkg::OP_LW, 2'd2, 2'd1));
        put(enc(cpu8_pkg::OP_SW, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_ADDI, 2'd1, 2'b01));
        put(enc(cpu8_pkg::OP_LW, 2'd3, 2'd1));      // Fill pattern byte
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd0));
        put(enc(cpu8_pkg::OP_LI, 2'd2, 2'b01));
        put(enc(cpu8_pkg::OP_SLL, 2'd2, 2'd3));
        put(enc(cpu8_pkg::OP_SLL, 2'd2, 2'd2));     // Loop head 0x20
        put(enc(cpu8_pkg::OP_MOV, 2'd1, 2'd2));
        put(enc(cpu8_pkg::OP_ADDI, 2'd1, 2'b10));
        put(enc(cpu8_pkg::OP_JAL, 2'd2, 2'd0));
        wr_pos = 8'h20;
        put(enc(cpu8_pkg::OP_ADDI, 2'd1, 2'b01));
        put(enc(cpu8_pkg::OP_SW, 2'd1, 2'd0));
        put(enc(cpu8_pkg::OP_BEQ, 2'd1, 2'd2));     // Leave after two passes
        put(enc(cpu8_pkg::OP_JMP, 2'd2, 2'd0));
        put(enc(cpu8_pkg::OP_SW, 2'd3, 2'd0));      // Link value
        end_seq();
        run_test(4, "memory and jumps");

        new_prog();
        random_body(40);
        end_seq();
        run_test(5, "random program a");

        new_prog();
        random_body(40);
        end_seq();
        run_test(6, "random program b");

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verif/cpu8_wb_mem.sv
`timescale 1ns/1ps

module cpu8_wb_mem
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] adr,
    input  logic [7:0] dat_w,
    output logic [7:0] dat_r,
    input  logic       we,
    input  logic       cyc,
    input  logic       stb,
    output logic       ack,
    input  logic [1:0] ack_delay,   // Wait cycles before ack
    input  logic       clear,       // Refill with the address pattern
    input  logic       load,        // No acks while the loader writes
    input  logic [7:0] load_adr,
    input  logic [7:0] load_dat
);

    logic [7:0] mem [256];
    logic [2:0] wait_cnt;

    assign dat_r = mem[adr];

    always @(posedge clk)
    begin
        if (clear)
        begin
            for (int i = 0; i < 256; i++)
            begin
                mem[i] <= 8'(i * 37) ^ 8'h5a;
            end
        end
        else if (load)
        begin
            mem[load_adr] <= load_dat;
        end
        else if (cyc && stb && we && ack)
        begin
            mem[adr] <= dat_w;
        end
    end

    always @(posedge clk)
    begin
        if (reset || load)
        begin
            ack      <= 1'b0;
            wait_cnt <= 3'd0;
        end
        else if (cyc && stb && !ack)
        begin
            if (wait_cnt >= {1'b0, ack_delay})
            begin
                ack      <= 1'b1;
                wait_cnt <= 3'd0;
            end
            else
            begin
                wait_cnt <= wait_cnt + 3'd1;
            end
        end
        else
        begin
            ack <= 1'b0;    // Single-cycle ack
        end
    end

endmodule
